// ==== design/rx_pkg.sv ====
package rx_pkg;

    //////////////////////////////
    // data widths
    //////////////////////////////

    // one ADC code, two's complement
    localparam int NADC = 8;

    // default number of interleaved lanes
    localparam int NTI_DEF = 16;

    // PRBS7, taps at n-6 and n-7
    localparam int NPRBS = 7;

    // error and total bit counters
    localparam int CNT_W = 32;

    // cycles held in wait after reset
    localparam int WAIT_CYCLES = 32;

    //////////////////////////////
    // enums
    //////////////////////////////

    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } rx_src_e;

    typedef enum logic [1:0] {
        ST_WAIT  = 2'd0,
        ST_SYNC  = 2'd1,
        ST_CHECK = 2'd2
    } bist_state_e;

endpackage

// ==== design/code_slicer.sv ====
`timescale 1ns/1ps

module code_slicer #(
    parameter int NTI = rx_pkg::NTI_DEF
) (
    input  logic                           clk_adc,
    input  logic                           cdr_rstb,
    input  logic signed [rx_pkg::NADC-1:0] code_i [NTI-1:0],
    input  logic signed [rx_pkg::NADC-1:0] threshold_i,
    output logic        [NTI-1:0]          bits_o
);

    // raw decisions, one per lane
    logic [NTI-1:0] above_thr;
    logic [NTI-1:0] bits_q;

    //////////////////////////////
    // comparator bank
    //////////////////////////////

    // signed compare, equal codes slice to 0
    always_comb begin
        for (int i = 0; i < NTI; i++) begin
            above_thr[i] = (code_i[i] > threshold_i);
        end
    end

    //////////////////////////////
    // decision register
    //////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            bits_q <= '0;
        end else begin
            bits_q <= above_thr;
        end
    end

    assign bits_o = bits_q;

endmodule

// ==== design/prbs_gen.sv ====
`timescale 1ns/1ps

module prbs_gen #(
    parameter int                      NTI       = rx_pkg::NTI_DEF,
    parameter logic [rx_pkg::NPRBS-1:0] PRBS_SEED = '1
) (
    input  logic           clk_adc,
    input  logic           cdr_rstb,
    input  logic           inj_err_i,
    output logic [NTI-1:0] bits_o
);
    import rx_pkg::*;

    // bit 0 of the state is the oldest stream bit
    logic [NPRBS-1:0]     state_q;
    logic [NTI+NPRBS-1:0] seq;
    logic [NTI-1:0]       word;
    logic [NTI-1:0]       inj_mask;
    logic [NTI-1:0]       bits_q;

    // extend the last NPRBS bits by NTI new ones
    function automatic logic [NTI+NPRBS-1:0] extend_seq(input logic [NPRBS-1:0] hist);
        logic [NTI+NPRBS-1:0] s;
        s = '0;
        s[NPRBS-1:0] = hist;
        // b[n] = b[n-6] ^ b[n-7]
        for (int i = 0; i < NTI; i++) begin
            s[NPRBS+i] = s[i+1] ^ s[i];
        end
        return s;
    endfunction

    assign seq  = extend_seq(state_q);
    assign word = seq[NPRBS +: NTI];

    // single flipped bit on lane 0
    assign inj_mask = {{(NTI-1){1'b0}}, inj_err_i};

    //////////////////////////////
    // state and output word
    //////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= PRBS_SEED;
            bits_q  <= '0;
        end else begin
            // state advances from the clean word only
            state_q <= seq[NTI +: NPRBS];
            bits_q  <= word ^ inj_mask;
        end
    end

    assign bits_o = bits_q;

endmodule

// ==== design/prbs_checker.sv ====
`timescale 1ns/1ps

module prbs_checker #(
    parameter int NTI = rx_pkg::NTI_DEF
) (
    input  logic                     clk_adc,
    input  logic                     cdr_rstb,
    input  logic [NTI-1:0]           adc_bits_i,
    input  logic [NTI-1:0]           bist_bits_i,
    input  rx_pkg::rx_src_e          src_sel_i,
    input  logic                     hist_load_i,
    input  logic                     count_en_i,
    input  logic                     cnt_clear_i,
    output logic [rx_pkg::CNT_W-1:0] err_count_o,
    output logic [rx_pkg::CNT_W-1:0] total_count_o
);
    import rx_pkg::*;

    localparam int ERR_W = $clog2(NTI + 1);

    logic [NTI-1:0]       rx_word;
    // received history, bit 0 oldest
    logic [NPRBS-1:0]     hist_q;
    logic [NTI+NPRBS-1:0] stream;
    logic [NTI-1:0]       err_vec;
    logic [ERR_W-1:0]     err_num;
    logic [CNT_W:0]       err_sum;
    logic [CNT_W:0]       total_sum;
    logic [CNT_W-1:0]     err_cnt_q;
    logic [CNT_W-1:0]     total_cnt_q;

    //////////////////////////////
    // source select
    //////////////////////////////

    assign rx_word = (src_sel_i == SRC_BIST) ? bist_bits_i : adc_bits_i;

    // history below, current word above
    assign stream = {rx_word, hist_q};

    //////////////////////////////
    // self-synchronizing check
    //////////////////////////////

    // lane i sits at stream[NPRBS+i], its taps at i+1 and i
    always_comb begin
        for (int i = 0; i < NTI; i++) begin
            err_vec[i] = stream[NPRBS+i] ^ stream[i+1] ^ stream[i];
        end
    end

    // number of failing lanes this word
    always_comb begin
        err_num = '0;
        for (int i = 0; i < NTI; i++) begin
            err_num = err_num + ERR_W'(err_vec[i]);
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist_q <= '0;
        end else if (hist_load_i || count_en_i) begin
            hist_q <= stream[NTI +: NPRBS];
        end
    end

    //////////////////////////////
    // saturating counters
    //////////////////////////////

    // one spare bit catches the wrap
    assign err_sum   = {1'b0, err_cnt_q} + (CNT_W+1)'(err_num);
    assign total_sum = {1'b0, total_cnt_q} + (CNT_W+1)'(NTI);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            err_cnt_q   <= '0;
            total_cnt_q <= '0;
        end else if (cnt_clear_i) begin
            err_cnt_q   <= '0;
            total_cnt_q <= '0;
        end else if (count_en_i) begin
            err_cnt_q   <= err_sum[CNT_W] ? '1 : err_sum[CNT_W-1:0];
            total_cnt_q <= total_sum[CNT_W] ? '1 : total_sum[CNT_W-1:0];
        end
    end

    assign err_count_o   = err_cnt_q;
    assign total_count_o = total_cnt_q;

endmodule

// ==== design/bist_ctrl.sv ====
`timescale 1ns/1ps

module bist_ctrl (
    input  logic clk_adc,
    input  logic cdr_rstb,
    input  logic restart_i,
    output logic ctl_valid_o,
    output logic hist_load_o,
    output logic count_en_o,
    output logic cnt_clear_o
);
    import rx_pkg::*;

    localparam int                WAIT_W    = $clog2(WAIT_CYCLES);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(WAIT_CYCLES - 1);

    bist_state_e       state_q;
    bist_state_e       state_d;
    logic [WAIT_W-1:0] wait_cnt_q;
    logic              wait_done;
    logic              ctl_valid_q;

    //////////////////////////////
    // reset wait
    //////////////////////////////

    // counter parks on its last value
    assign wait_done = (wait_cnt_q == WAIT_LAST);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt_q  <= '0;
            ctl_valid_q <= 1'b0;
        end else begin
            if (!wait_done) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end
            // rises on the 32nd edge, then holds
            ctl_valid_q <= wait_done;
        end
    end

    //////////////////////////////
    // phase FSM
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_WAIT: begin
                if (wait_done) begin
                    state_d = ST_SYNC;
                end
            end
            // one cycle of history fill
            ST_SYNC: begin
                state_d = restart_i ? ST_SYNC : ST_CHECK;
            end
            ST_CHECK: begin
                if (restart_i) begin
                    state_d = ST_SYNC;
                end
            end
            default: begin
                state_d = ST_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= ST_WAIT;
        end else begin
            state_q <= state_d;
        end
    end

    // clear lands on the same edge that enters sync
    assign cnt_clear_o = (state_d == ST_SYNC) && ((state_q == ST_WAIT) || restart_i);
    assign hist_load_o = (state_q == ST_SYNC);
    assign count_en_o  = (state_q == ST_CHECK);
    assign ctl_valid_o = ctl_valid_q;

endmodule

// ==== design/rx_bist_top.sv ====
`timescale 1ns/1ps

module rx_bist_top #(
    parameter int                       NTI       = rx_pkg::NTI_DEF,
    parameter logic [rx_pkg::NPRBS-1:0] PRBS_SEED = '1
) (
    input  logic                           clk_adc,
    input  logic                           cdr_rstb,
    input  logic signed [rx_pkg::NADC-1:0] code_i [NTI-1:0],
    input  logic signed [rx_pkg::NADC-1:0] threshold_i,
    input  rx_pkg::rx_src_e                src_sel_i,
    input  logic                           inj_err_i,
    input  logic                           restart_i,
    output logic                           ctl_valid_o,
    output logic        [rx_pkg::CNT_W-1:0] err_count_o,
    output logic        [rx_pkg::CNT_W-1:0] total_count_o
);

    // sliced ADC word and BIST word
    logic [NTI-1:0] slice_bits;
    logic [NTI-1:0] gen_bits;

    // controller to checker
    logic hist_load;
    logic count_en;
    logic cnt_clear;

    //////////////////////////////
    // phase control
    //////////////////////////////

    bist_ctrl i_bist_ctrl (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .restart_i   (restart_i),
        .ctl_valid_o (ctl_valid_o),
        .hist_load_o (hist_load),
        .count_en_o  (count_en),
        .cnt_clear_o (cnt_clear)
    );

    //////////////////////////////
    // ADC decisions
    //////////////////////////////

    code_slicer #(
        .NTI (NTI)
    ) i_code_slicer (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .code_i      (code_i),
        .threshold_i (threshold_i),
        .bits_o      (slice_bits)
    );

    //////////////////////////////
    // BIST source
    //////////////////////////////

    prbs_gen #(
        .NTI       (NTI),
        .PRBS_SEED (PRBS_SEED)
    ) i_prbs_gen (
        .clk_adc   (clk_adc),
        .cdr_rstb  (cdr_rstb),
        .inj_err_i (inj_err_i),
        .bits_o    (gen_bits)
    );

    //////////////////////////////
    // checker and counters
    //////////////////////////////

    prbs_checker #(
        .NTI (NTI)
    ) i_prbs_checker (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .adc_bits_i    (slice_bits),
        .bist_bits_i   (gen_bits),
        .src_sel_i     (src_sel_i),
        .hist_load_i   (hist_load),
        .count_en_i    (count_en),
        .cnt_clear_i   (cnt_clear),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

// ==== sim/rx_bist_chk.sv ====
`timescale 1ns/1ps

module rx_bist_chk #(
    parameter int NTI = rx_pkg::NTI_DEF
) (
    input logic                     clk_adc,
    input logic                     cdr_rstb,
    input logic                     ctl_valid_i,
    input logic [rx_pkg::CNT_W-1:0] err_count_i,
    input logic [rx_pkg::CNT_W-1:0] total_count_i
);
    import rx_pkg::*;

    // sticky flags, one per property
    logic total_step_bad = 1'b0;
    logic err_bound_bad  = 1'b0;
    logic valid_drop_bad = 1'b0;
    logic assert_failed;

    assign assert_failed = total_step_bad | err_bound_bad | valid_drop_bad;

    //////////////////////////////
    // counter properties
    //////////////////////////////

    // step of NTI, a clear, or saturation
    total_step: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        (total_count_i != $past(total_count_i)) |->
            ((total_count_i == $past(total_count_i) + CNT_W'(NTI)) ||
             (total_count_i == '0) || (total_count_i == '1))
    ) else begin
        $error("total_count_o moved by a step other than NTI");
        total_step_bad = 1'b1;
    end

    err_bound: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        err_count_i <= total_count_i
    ) else begin
        $error("err_count_o is larger than total_count_o");
        err_bound_bad = 1'b1;
    end

    //////////////////////////////
    // controller property
    //////////////////////////////

    valid_hold: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        !$fell(ctl_valid_i)
    ) else begin
        $error("ctl_valid_o fell while out of reset");
        valid_drop_bad = 1'b1;
    end

endmodule

bind rx_bist_top rx_bist_chk #(
    .NTI (NTI)
) i_chk (
    .clk_adc       (clk_adc),
    .cdr_rstb      (cdr_rstb),
    .ctl_valid_i   (ctl_valid_o),
    .err_count_i   (err_count_o),
    .total_count_i (total_count_o)
);

// ==== sim/tb_rx_bist.sv ====
`timescale 1ns/1ps

module tb_rx_bist;
    import rx_pkg::*;

    localparam int               NTI          = NTI_DEF;
    localparam logic [NPRBS-1:0] SEED         = 7'h7f;
    localparam int               MAX_CYCLES   = 2000;
    localparam int               CLEAN_CYCLES = 100;
    localparam int               ADC_CYCLES   = 50;

    logic                   clk_adc;
    logic                   cdr_rstb;
    logic signed [NADC-1:0] code [NTI-1:0];
    logic signed [NADC-1:0] threshold;
    rx_src_e                src_sel;
    logic                   inj_err;
    logic                   restart;
    logic                   ctl_valid;
    logic [CNT_W-1:0]       err_count;
    logic [CNT_W-1:0]       total_count;

    integer seed;
    int     cycle_cnt = 0;
    // reference stream, bit 0 is b[n-7]
    logic [NPRBS-1:0] ref_hist;

    rx_bist_top #(
        .NTI       (NTI),
        .PRBS_SEED (SEED)
    ) i_dut (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .code_i        (code),
        .threshold_i   (threshold),
        .src_sel_i     (src_sel),
        .inj_err_i     (inj_err),
        .restart_i     (restart),
        .ctl_valid_o   (ctl_valid),
        .err_count_o   (err_count),
        .total_count_o (total_count)
    );

    initial clk_adc = 1'b0;
    always #2 clk_adc = ~clk_adc;

    // runaway guard
    always @(posedge clk_adc) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic compare(input logic [63:0] expected, input logic [63:0] actual,
                           input string what);
        if (expected !== actual) begin
            $display("mismatch at %0t ns: %s, expected %0d, actual %0d",
                     $time, what, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_adc);
    endtask

    task automatic pulse_restart();
        restart = 1'b1;
        wait_cycles(1);
        restart = 1'b0;
    endtask

    // signed code that slices to the wanted bit
    function automatic logic signed [NADC-1:0] code_for_bit(input logic one);
        int v;
        if (one) begin
            v = int'(threshold) + 1 + int'($unsigned($random(seed)) % (127 - threshold));
        end else if (($unsigned($random(seed)) % 4) == 0) begin
            // exact threshold must slice to 0
            v = int'(threshold);
        end else begin
            v = -128 + int'($unsigned($random(seed)) % (int'(threshold) + 129));
        end
        return NADC'(v);
    endfunction

    // next NTI stream bits as codes, lane 0 first
    task automatic drive_adc_word(input int flip_lane);
        logic nb;
        for (int i = 0; i < NTI; i++) begin
            nb       = ref_hist[1] ^ ref_hist[0];
            ref_hist = {nb, ref_hist[NPRBS-1:1]};
            code[i]  = code_for_bit((i == flip_lane) ? ~nb : nb);
        end
        wait_cycles(1);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_reset_wait();
        repeat (5) @(posedge clk_adc);
        @(negedge clk_adc);
        cdr_rstb = 1'b1;
        compare(0, ctl_valid, "ctl_valid_o right after reset");
        compare(0, err_count, "err_count_o right after reset");
        compare(0, total_count, "total_count_o right after reset");
        wait_cycles(WAIT_CYCLES - 1);
        compare(0, ctl_valid, "ctl_valid_o after 31 edges");
        wait_cycles(1);
        compare(1, ctl_valid, "ctl_valid_o after 32 edges");
    endtask

    task automatic test_clean_bist();
        wait_cycles(CLEAN_CYCLES);
        compare(0, err_count, "errors on the clean BIST stream");
        // sync phase uses up the first cycle
        compare(NTI * (CLEAN_CYCLES - 1), total_count, "total bits on the clean BIST stream");
    endtask

    task automatic test_inject();
        pulse_restart();
        compare(0, total_count, "total_count_o cleared by restart");
        wait_cycles(3);
        inj_err = 1'b1;
        wait_cycles(1);
        inj_err = 1'b0;
        wait_cycles(5);
        compare(3, err_count, "errors from one injected bit");
    endtask

    task automatic test_adc_path();
        int flip;
        src_sel = SRC_ADC;
        // slicer register holds stream bits before sync
        drive_adc_word(-1);
        drive_adc_word(-1);
        restart = 1'b1;
        drive_adc_word(-1);
        restart = 1'b0;
        repeat (ADC_CYCLES) drive_adc_word(-1);
        compare(0, err_count, "errors on the clean ADC stream");
        compare(NTI * (ADC_CYCLES - 1), total_count, "total bits on the clean ADC stream");
        flip = int'($unsigned($random(seed)) % NTI);
        drive_adc_word(flip);
        repeat (4) drive_adc_word(-1);
        compare(3, err_count, "errors from one flipped ADC lane");
    endtask

    task automatic test_restart();
        pulse_restart();
        compare(0, err_count, "err_count_o one cycle after restart");
        compare(0, total_count, "total_count_o one cycle after restart");
        compare(1, ctl_valid, "ctl_valid_o across restart");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        seed      = 28;
        cdr_rstb  = 1'b0;
        threshold = 8'sd20;
        src_sel   = SRC_BIST;
        inj_err   = 1'b0;
        restart   = 1'b0;
        ref_hist  = 7'h01;
        for (int i = 0; i < NTI; i++) begin
            code[i] = '0;
        end

        test_reset_wait();
        test_clean_bist();
        test_inject();
        test_adc_path();
        test_restart();
        wait_cycles(2);

        if (i_dut.i_chk.assert_failed) begin
            $display("an assertion in rx_bist_chk failed during the run");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
design/rx_pkg.sv
design/code_slicer.sv
design/prbs_gen.sv
design/prbs_checker.sv
design/bist_ctrl.sv
design/rx_bist_top.sv
sim/rx_bist_chk.sv
sim/tb_rx_bist.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_rx_bist
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "available targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
